// File: icache_pkg.sv
/* Sizes, address split and burst codes shared by every instruction cache block.
   Import by wildcard in the module header of any file that needs them */
package icache_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    // Instruction width, fixed whatever the ISA
    localparam int ILEN       = 32;
    // Byte address width on both ports
    localparam int ADDR_W     = 32;
    // One memory beat
    localparam int MEM_DATA_W = 32;

    //////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////

    // Instructions per line
    localparam int LINE_WORDS  = 4;
    // Line payload, data only
    localparam int BLOCK_W     = LINE_WORDS * ILEN;
    // Number of lines, direct mapped
    localparam int CACHE_DEPTH = 16;

    // Address split: tag | index | word | byte
    localparam int OFFSET_W    = $clog2(BLOCK_W / 8);
    localparam int INDEX_W     = $clog2(CACHE_DEPTH);
    localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORD_IDX_W  = $clog2(LINE_WORDS);
    localparam int BYTE_OFF_W  = OFFSET_W - WORD_IDX_W;

    //////////////////////////////////////////////////
    // Memory read burst fields
    //////////////////////////////////////////////////

    localparam int ARLEN_W   = 8;
    localparam int ARSIZE_W  = 3;
    localparam int ARBURST_W = 2;

    // One line per burst, 4-byte beats, incrementing
    localparam logic [ARLEN_W-1:0]   BURST_LEN  = ARLEN_W'(LINE_WORDS - 1);
    localparam logic [ARBURST_W-1:0] BURST_INCR = 2'b01;
    localparam logic [ARSIZE_W-1:0]  BEAT_SIZE  = 3'd2;

endpackage

// File: icache_lookup_if.sv
/* Tag lookup and word read between the fetcher and the line storage.
   Results come back one cycle after ren and hold until the next ren */
`timescale 1ns/100ps

interface icache_lookup_if
    import icache_pkg::*;
    ();

    // Lookup strobe, one cycle
    logic              ren;
    // Full fetch address, offset selects the word
    logic [ADDR_W-1:0] raddr;
    // Selected instruction word
    logic [ILEN-1:0]   rdata;
    // Line valid and tag match
    logic              hit;

    modport fetcher (
        output ren,
        output raddr,
        input  rdata,
        input  hit
    );

    modport blocks (
        input  ren,
        input  raddr,
        output rdata,
        output hit
    );

endinterface

// File: icache_fill_if.sv
/* Line write and flush clear from the memory controller into the line storage.
   wen writes a full line, flush clears every valid bit in one cycle */
`timescale 1ns/100ps

interface icache_fill_if
    import icache_pkg::*;
    ();

    // Full line write strobe
    logic               wen;
    // Line address, tag and index are used
    logic [ADDR_W-1:0]  waddr;
    // Whole line, lowest word in the low bits
    logic [BLOCK_W-1:0] wdata;
    // Clear all valid bits
    logic               flush;

    modport memctrl (
        output wen,
        output waddr,
        output wdata,
        output flush
    );

    modport blocks (
        input  wen,
        input  waddr,
        input  wdata,
        input  flush
    );

endinterface

// File: icache_fetcher.sv
/* Fetch side of the cache: takes one request, looks it up, asks for a fill on miss
   and holds the read data until the fetch unit takes it */
`timescale 1ns/100ps

module icache_fetcher
    import icache_pkg::*;
    (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              flush_blocks,
    input  logic              ctrl_arvalid,
    output logic              ctrl_arready,
    input  logic [ADDR_W-1:0] ctrl_araddr,
    output logic              ctrl_rvalid,
    input  logic              ctrl_rready,
    output logic [ILEN-1:0]   ctrl_rdata,
    icache_lookup_if.fetcher  lookup,
    output logic              miss_req,
    output logic [ADDR_W-1:0] miss_addr,
    input  logic              fill_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_wait_fill,
        st_respond
    } fetch_state_t;

    fetch_state_t      state_q;
    // Low while ren goes out, high while the result is checked
    logic              lk_wait_q;
    logic [ADDR_W-1:0] addr_q;
    logic              accept;
    logic              lookup_hit;

    //////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////

    // Only one request in flight, none taken while a flush is pending
    assign ctrl_arready = (state_q == st_idle) && !flush_blocks;
    assign accept       = ctrl_arvalid && ctrl_arready;

    // Result phase of a lookup that found the line
    assign lookup_hit = (state_q == st_lookup) && lk_wait_q && lookup.hit;

    assign lookup.ren   = (state_q == st_lookup) && !lk_wait_q;
    assign lookup.raddr = addr_q;

    // Fill always covers the whole line
    assign miss_addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign ctrl_rvalid = (state_q == st_respond);

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            lk_wait_q <= 1'b0;
            miss_req  <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q   <= st_lookup;
                        lk_wait_q <= 1'b0;
                    end
                end
                st_lookup: begin
                    if (!lk_wait_q) begin
                        lk_wait_q <= 1'b1;
                    end else if (lookup.hit) begin
                        state_q <= st_respond;
                    end else begin
                        // Miss, hand the line address to the memory side
                        state_q  <= st_wait_fill;
                        miss_req <= 1'b1;
                    end
                end
                st_wait_fill: begin
                    // Line is written now, look it up again
                    if (fill_done) begin
                        miss_req  <= 1'b0;
                        state_q   <= st_lookup;
                        lk_wait_q <= 1'b0;
                    end
                end
                default: begin
                    if (ctrl_rready) begin
                        state_q <= st_idle;
                    end
                end
            endcase
        end
    end

    // Address and response payload
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= ctrl_araddr;
        end
        if (lookup_hit) begin
            ctrl_rdata <= lookup.rdata;
        end
    end

endmodule

// File: icache_blocks.sv
/* Line storage of the direct-mapped cache: valid bits, tags and data.
   Lookups are registered, fills write a whole line in one cycle */
`timescale 1ns/100ps

module icache_blocks
    import icache_pkg::*;
    (
    input  logic          aclk,
    input  logic          rst_n,
    icache_lookup_if.blocks lookup,
    icache_fill_if.blocks   fill
);

    logic [TAG_W-1:0]      tag_mem  [CACHE_DEPTH];
    logic [BLOCK_W-1:0]    data_mem [CACHE_DEPTH];
    logic [CACHE_DEPTH-1:0] valid_q;

    // Read address fields
    logic [INDEX_W-1:0]    rd_index;
    logic [TAG_W-1:0]      rd_tag;
    logic [WORD_IDX_W-1:0] rd_word;
    // Write address fields
    logic [INDEX_W-1:0]    wr_index;
    logic [TAG_W-1:0]      wr_tag;

    // Lookup result registers
    logic                  valid_rd_q;
    logic [TAG_W-1:0]      tag_rd_q;
    logic [TAG_W-1:0]      req_tag_q;

    assign rd_index = lookup.raddr[OFFSET_W +: INDEX_W];
    assign rd_tag   = lookup.raddr[ADDR_W-1 -: TAG_W];
    assign rd_word  = lookup.raddr[BYTE_OFF_W +: WORD_IDX_W];
    assign wr_index = fill.waddr[OFFSET_W +: INDEX_W];
    assign wr_tag   = fill.waddr[ADDR_W-1 -: TAG_W];

    //////////////////////////////////////////////////
    // Valid bits
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            // Flush never overlaps a fill
            if (fill.flush) begin
                valid_q <= '0;
            end else if (fill.wen) begin
                valid_q[wr_index] <= 1'b1;
            end
            if (lookup.ren) begin
                valid_rd_q <= valid_q[rd_index];
            end
        end
    end

    //////////////////////////////////////////////////
    // Tag and data arrays
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (fill.wen) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= fill.wdata;
        end
        // Word picked by the offset, tags compared after the register
        if (lookup.ren) begin
            tag_rd_q     <= tag_mem[rd_index];
            req_tag_q    <= rd_tag;
            lookup.rdata <= data_mem[rd_index][rd_word*ILEN +: ILEN];
        end
    end

    assign lookup.hit = valid_rd_q && (tag_rd_q == req_tag_q);

endmodule

// File: icache_memctrl.sv
/* Memory side of the cache: one incrementing burst per missed line, line assembly,
   line write into storage and FENCE.i flush execution */
`timescale 1ns/100ps

module icache_memctrl
    import icache_pkg::*;
    (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  logic                 flush_blocks,
    output logic                 flush_ack,
    input  logic                 miss_req,
    input  logic [ADDR_W-1:0]    miss_addr,
    output logic                 fill_done,
    output logic                 icache_arvalid,
    input  logic                 icache_arready,
    output logic [ADDR_W-1:0]    icache_araddr,
    output logic [ARLEN_W-1:0]   icache_arlen,
    output logic [ARSIZE_W-1:0]  icache_arsize,
    output logic [ARBURST_W-1:0] icache_arburst,
    input  logic                 icache_rvalid,
    output logic                 icache_rready,
    input  logic [MEM_DATA_W-1:0] icache_rdata,
    input  logic                 icache_rlast,
    icache_fill_if.memctrl       fill
);

    typedef enum logic [2:0] {
        ms_idle,
        ms_req,
        ms_burst,
        ms_write,
        ms_done,
        ms_flush,
        ms_ack
    } mem_state_t;

    mem_state_t            state_q;
    logic [WORD_IDX_W-1:0] beat_q;
    logic [BLOCK_W-1:0]    line_q;
    logic                  beat;

    assign beat = (state_q == ms_burst) && icache_rvalid;

    //////////////////////////////////////////////////
    // Burst and flush sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ms_idle;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ms_idle: begin
                    // A waiting miss goes before the flush
                    if (miss_req) begin
                        state_q <= ms_req;
                    end else if (flush_blocks) begin
                        state_q <= ms_flush;
                    end
                end
                ms_req: begin
                    if (icache_arready) begin
                        state_q <= ms_burst;
                        beat_q  <= '0;
                    end
                end
                ms_burst: begin
                    if (beat) begin
                        beat_q <= beat_q + 1'b1;
                        if (icache_rlast) begin
                            state_q <= ms_write;
                        end
                    end
                end
                ms_write: state_q <= ms_done;
                ms_flush: state_q <= ms_ack;
                default:  state_q <= ms_idle;
            endcase
        end
    end

    // Burst address and line assembly, lowest word first
    always_ff @(posedge aclk) begin
        if (state_q == ms_idle && miss_req) begin
            icache_araddr <= miss_addr;
        end
        if (beat) begin
            line_q[beat_q*MEM_DATA_W +: MEM_DATA_W] <= icache_rdata;
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    assign icache_arvalid = (state_q == ms_req);
    assign icache_arlen   = BURST_LEN;
    assign icache_arsize  = BEAT_SIZE;
    assign icache_arburst = BURST_INCR;
    // Never stalls the memory during a burst
    assign icache_rready  = (state_q == ms_burst);

    assign fill.wen   = (state_q == ms_write);
    assign fill.waddr = icache_araddr;
    assign fill.wdata = line_q;
    assign fill.flush = (state_q == ms_flush);

    assign fill_done = (state_q == ms_done);
    assign flush_ack = (state_q == ms_ack);

endmodule

// File: icache_top.sv
/* Instruction cache top: fetch port on one side, burst read port to memory on the
   other, flush handshake for FENCE.i */
`timescale 1ns/100ps

module icache_top
    import icache_pkg::*;
    (
    input  logic                  aclk,
    input  logic                  rst_n,
    // FENCE.i flush
    input  logic                  flush_blocks,
    output logic                  flush_ack,
    // Fetch unit port
    input  logic                  ctrl_arvalid,
    output logic                  ctrl_arready,
    input  logic [ADDR_W-1:0]     ctrl_araddr,
    output logic                  ctrl_rvalid,
    input  logic                  ctrl_rready,
    output logic [ILEN-1:0]       ctrl_rdata,
    // Central memory read port
    output logic                  icache_arvalid,
    input  logic                  icache_arready,
    output logic [ADDR_W-1:0]     icache_araddr,
    output logic [ARLEN_W-1:0]    icache_arlen,
    output logic [ARSIZE_W-1:0]   icache_arsize,
    output logic [ARBURST_W-1:0]  icache_arburst,
    input  logic                  icache_rvalid,
    output logic                  icache_rready,
    input  logic [MEM_DATA_W-1:0] icache_rdata,
    input  logic                  icache_rlast
);

    // Miss handshake between fetcher and memory controller
    logic              miss_req;
    logic [ADDR_W-1:0] miss_addr;
    logic              fill_done;

    icache_lookup_if lookup_bus ();
    icache_fill_if   fill_bus ();

    //////////////////////////////////////////////////
    // Fetcher
    //////////////////////////////////////////////////

    icache_fetcher fetcher_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .flush_blocks (flush_blocks),
        .ctrl_arvalid (ctrl_arvalid),
        .ctrl_arready (ctrl_arready),
        .ctrl_araddr  (ctrl_araddr),
        .ctrl_rvalid  (ctrl_rvalid),
        .ctrl_rready  (ctrl_rready),
        .ctrl_rdata   (ctrl_rdata),
        .lookup       (lookup_bus.fetcher),
        .miss_req     (miss_req),
        .miss_addr    (miss_addr),
        .fill_done    (fill_done)
    );

    // Line storage
    icache_blocks blocks_i (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .lookup (lookup_bus.blocks),
        .fill   (fill_bus.blocks)
    );

    //////////////////////////////////////////////////
    // Memory controller
    //////////////////////////////////////////////////

    icache_memctrl memctrl_i (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .flush_blocks   (flush_blocks),
        .flush_ack      (flush_ack),
        .miss_req       (miss_req),
        .miss_addr      (miss_addr),
        .fill_done      (fill_done),
        .icache_arvalid (icache_arvalid),
        .icache_arready (icache_arready),
        .icache_araddr  (icache_araddr),
        .icache_arlen   (icache_arlen),
        .icache_arsize  (icache_arsize),
        .icache_arburst (icache_arburst),
        .icache_rvalid  (icache_rvalid),
        .icache_rready  (icache_rready),
        .icache_rdata   (icache_rdata),
        .icache_rlast   (icache_rlast),
        .fill           (fill_bus.memctrl)
    );

endmodule

// File: icache_chk.sv
/* Handshake and flush assertions, bound into the cache top level */
`timescale 1ns/100ps

module icache_chk
    import icache_pkg::*;
    (
    input logic                 aclk,
    input logic                 rst_n,
    input logic                 flush_blocks,
    input logic                 flush_ack,
    input logic                 ctrl_rvalid,
    input logic                 ctrl_rready,
    input logic [ILEN-1:0]      ctrl_rdata,
    input logic                 icache_arvalid,
    input logic                 icache_arready,
    input logic [ADDR_W-1:0]    icache_araddr,
    input logic [ARLEN_W-1:0]   icache_arlen,
    input logic [ARSIZE_W-1:0]  icache_arsize,
    input logic [ARBURST_W-1:0] icache_arburst
);

    // Burst request held until memory takes it
    ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        icache_arvalid && !icache_arready |=> icache_arvalid && $stable(icache_araddr)
            && $stable(icache_arlen) && $stable(icache_arsize) && $stable(icache_arburst))
        else $error("memory read request changed before arready");

    // Fetch response held under back-pressure
    r_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        ctrl_rvalid && !ctrl_rready |=> ctrl_rvalid && $stable(ctrl_rdata))
        else $error("fetch response changed before rready");

    ack_in_req: assert property (@(posedge aclk) disable iff (!rst_n)
        flush_ack |-> flush_blocks)
        else $error("flush_ack without flush_blocks");

endmodule

bind icache_top icache_chk chk_i (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .flush_blocks   (flush_blocks),
    .flush_ack      (flush_ack),
    .ctrl_rvalid    (ctrl_rvalid),
    .ctrl_rready    (ctrl_rready),
    .ctrl_rdata     (ctrl_rdata),
    .icache_arvalid (icache_arvalid),
    .icache_arready (icache_arready),
    .icache_araddr  (icache_araddr),
    .icache_arlen   (icache_arlen),
    .icache_arsize  (icache_arsize),
    .icache_arburst (icache_arburst)
);

// File: tb_icache.sv
/* Testbench for the instruction cache: drives fetches, models burst memory and checks
   every response against a scrambled-address memory image */
`timescale 1ns/100ps

module tb_icache
    import icache_pkg::*;
    ();

    // Fetch count over all tests and worst-case cycles per missed fetch
    localparam int FETCH_COUNT = 210;
    localparam int MISS_CYCLES = 80;
    localparam int CLK_PERIOD  = 20;

    logic                  aclk = 1'b0;
    logic                  rst_n;
    logic                  flush_blocks, flush_ack;
    logic                  ctrl_arvalid, ctrl_arready, ctrl_rvalid, ctrl_rready;
    logic [ADDR_W-1:0]     ctrl_araddr;
    logic [ILEN-1:0]       ctrl_rdata;
    logic                  icache_arvalid, icache_arready, icache_rvalid, icache_rready;
    logic                  icache_rlast;
    logic [ADDR_W-1:0]     icache_araddr;
    logic [ARLEN_W-1:0]    icache_arlen;
    logic [ARSIZE_W-1:0]   icache_arsize;
    logic [ARBURST_W-1:0]  icache_arburst;
    logic [MEM_DATA_W-1:0] icache_rdata;

    int                    seed = 48749;
    bit                    stress = 1'b0;
    int                    errors, pass_count, fail_count, burst_count, resp_count;
    logic [ADDR_W-1:0]     last_burst_addr;
    // Accepted fetch addresses still waiting for data
    logic [ADDR_W-1:0]     expect_addr_q[$];

    icache_top dut_i (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // Memory image as a fixed scramble of the word address
    function automatic logic [ILEN-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] w;
        w = addr >> 2;
        return (w * 32'h9E37_79B9) ^ {w[15:0], w[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got, exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        if (errors == err0) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s", name);
        end
    endtask

    // One fetch that returns on the negedge after its response is taken
    task automatic fetch(input logic [ADDR_W-1:0] addr);
        int n0;
        n0           = resp_count;
        ctrl_arvalid = 1'b1;
        ctrl_araddr  = addr;
        do @(posedge aclk); while (!ctrl_arready);
        @(negedge aclk);
        ctrl_arvalid = 1'b0;
        while (resp_count == n0) @(negedge aclk);
    endtask

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    initial begin : mem_model
        logic [ADDR_W-1:0] base;
        int                i;
        icache_arready = 1'b0;
        icache_rvalid  = 1'b0;
        icache_rlast   = 1'b0;
        icache_rdata   = '0;
        @(posedge rst_n);
        forever begin
            // Address phase with arready held back at random under stress
            do begin
                @(negedge aclk);
                icache_rvalid  = 1'b0;
                icache_rlast   = 1'b0;
                icache_arready = stress ? (($random(seed) & 3) != 0) : 1'b1;
                @(posedge aclk);
            end while (!(icache_arvalid && icache_arready));
            base            = icache_araddr;
            last_burst_addr = base;
            // One line of 4-byte beats, AXI INCR burst
            expect_equal("icache_arlen", 32'(icache_arlen), 32'(LINE_WORDS - 1));
            expect_equal("icache_arsize", 32'(icache_arsize), 32'($clog2(MEM_DATA_W / 8)));
            expect_equal("icache_arburst", 32'(icache_arburst), 32'd1);
            // Beats in address order with random gaps
            for (i = 0; i < LINE_WORDS; i++) begin
                @(negedge aclk);
                icache_arready = 1'b0;
                icache_rvalid  = 1'b0;
                while (stress && (($random(seed) & 3) == 0)) @(negedge aclk);
                icache_rvalid = 1'b1;
                icache_rdata  = mem_word(base + ADDR_W'(i * 4));
                icache_rlast  = (i == LINE_WORDS - 1);
                do @(posedge aclk); while (!icache_rready);
            end
            burst_count++;
        end
    end

    // Fetch-side back-pressure
    always @(negedge aclk) begin
        ctrl_rready = stress ? (($random(seed) & 1) != 0) : 1'b1;
    end

    // Comparer of each taken response against the oldest accepted address
    always @(posedge aclk) begin : comparer
        logic [ADDR_W-1:0] a;
        if (ctrl_arvalid && ctrl_arready) begin
            expect_addr_q.push_back(ctrl_araddr);
        end
        if (ctrl_rvalid && ctrl_rready) begin
            resp_count++;
            if (expect_addr_q.size() == 0) begin
                $display("Response at %0t ns arrived with no fetch outstanding", $time);
                errors++;
            end else begin
                a = expect_addr_q.pop_front();
                expect_equal("ctrl_rdata", ctrl_rdata, mem_word(a));
            end
        end
    end

    // Watchdog
    initial begin
        #(FETCH_COUNT * MISS_CYCLES * CLK_PERIOD);
        $display("Timeout, the cache stopped answering fetches");
        $display("test failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        int                err0;
        int                b0;
        int                n;
        logic [ADDR_W-1:0] addr;
        rst_n        = 1'b0;
        flush_blocks = 1'b0;
        ctrl_arvalid = 1'b0;
        ctrl_araddr  = '0;
        ctrl_rready  = 1'b0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        @(negedge aclk);

        // Cold miss causes one burst to the line base
        err0 = errors;
        b0   = burst_count;
        fetch(32'h0000_1008);
        expect_equal("burst_count", 32'(burst_count), 32'(b0 + 1));
        expect_equal("icache_araddr", last_burst_addr, 32'h0000_1000);
        finish_test("cold miss", err0);

        // Rest of the same line hits
        err0 = errors;
        b0   = burst_count;
        fetch(32'h0000_1000);
        fetch(32'h0000_1004);
        fetch(32'h0000_100C);
        expect_equal("burst_count", 32'(burst_count), 32'(b0));
        finish_test("hits", err0);

        // Same index with different tags
        err0 = errors;
        b0   = burst_count;
        fetch(32'h0000_2040);
        fetch(32'h0001_2040);
        fetch(32'h0000_2044);
        expect_equal("burst_count", 32'(burst_count), 32'(b0 + 3));
        finish_test("conflict eviction", err0);

        // Random traffic over 64 lines with stalls on every channel
        err0   = errors;
        stress = 1'b1;
        for (n = 0; n < 200; n++) begin
            addr = 32'($random(seed)) & 32'h0000_03FC;
            fetch(addr);
        end
        stress = 1'b0;
        expect_equal("pending responses", 32'(expect_addr_q.size()), 32'd0);
        finish_test("back-pressure", err0);

        // Flush drops a cached line
        err0 = errors;
        fetch(32'h0000_3004);
        b0 = burst_count;
        fetch(32'h0000_3008);
        expect_equal("burst_count", 32'(burst_count), 32'(b0));
        flush_blocks = 1'b1;
        do @(posedge aclk); while (!flush_ack);
        @(negedge aclk);
        flush_blocks = 1'b0;
        b0 = burst_count;
        fetch(32'h0000_3004);
        expect_equal("burst_count", 32'(burst_count), 32'(b0 + 1));
        finish_test("flush", err0);

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: project.f
icache_pkg.sv
icache_lookup_if.sv
icache_fill_if.sv
icache_fetcher.sv
icache_blocks.sv
icache_memctrl.sv
icache_top.sv
icache_chk.sv
tb_icache.sv

// File: run.sh
#!/bin/bash
# Build the instruction cache testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f project.f --top-module tb_icache \
    && ./obj_dir/Vtb_icache | tee /dev/stderr | grep -q "test passed" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
